//--- hw/uart_rx_pkg.sv
package uart_rx_pkg;

    // Width of a received character, fixed for the whole receiver
    localparam int DATA_BITS = 8;

    // Number of baud ticks per serial bit
    localparam int OVERSAMPLE = 16;

    // Parity mode shared by the sampler and the checker
    typedef enum logic [1:0] {
        PARITY_NONE,
        PARITY_EVEN,
        PARITY_ODD
    } rx_parity_t;

    // States of the receive FSM
    typedef enum logic [2:0] {
        RX_IDLE,    // Line idle and waiting for a falling edge
        RX_START,   // Counting to the middle of the start bit
        RX_DATA,    // Shifting in the data bits LSB first
        RX_PARITY,  // Capturing the parity bit
        RX_STOP,    // Checking the stop bits
        RX_DONE     // Frame complete for one cycle
    } rx_state_t;

    // Raw frame handed from the sampler to the checker
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 parity_bit;  // Parity bit as seen on the line
        logic                 framing;     // Some stop bit was sampled low
    } rx_frame_t;

    // Error flags that travel with each received character
    typedef struct packed {
        logic parity;
        logic framing;
    } rx_err_t;

    // Checked character as stored in the FIFO
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        rx_err_t              err;
    } rx_word_t;

endpackage

//--- hw/uart_rx_oversample.sv
module uart_rx_oversample #(
    parameter int CLK_FREQ  = 50_000_000,
    parameter int BAUD_RATE = 115_200
) (
    input  logic Clk,
    input  logic Rst,
    input  logic rx,        // Serial line straight from the pin
    input  logic restart,   // Realigns the tick phase to a start edge
    output logic rx_sync,
    output logic tick
);

    // Clock cycles between two baud ticks
    localparam int DIVIDER = CLK_FREQ / (uart_rx_pkg::OVERSAMPLE * BAUD_RATE);
    localparam int CNT_W   = (DIVIDER > 1) ? $clog2(DIVIDER) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DIVIDER - 1);

    logic             rx_meta;   // First synchronizer stage and may go metastable
    logic [CNT_W-1:0] div_cnt;   // Counts down to the next tick

    // Two flops bring the asynchronous line into the Clk domain
    // Both stages come out of reset high since the line idles high
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;   // Two cycles behind the pin
        end
    end

    // Free running divider that pulses tick once every DIVIDER cycles
    // A restart reloads it so the next tick lands DIVIDER cycles after the start edge
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            div_cnt <= RELOAD;
            tick    <= 1'b0;
        end else if (restart) begin
            div_cnt <= RELOAD;   // Throw away the partial period
            tick    <= 1'b0;
        end else if (div_cnt == '0) begin
            div_cnt <= RELOAD;
            tick    <= 1'b1;      // Single cycle pulse
        end else begin
            div_cnt <= div_cnt - 1'b1;
            tick    <= 1'b0;
        end
    end

endmodule

//--- hw/uart_rx_sampler.sv
module uart_rx_sampler #(
    parameter int                      STOP_BITS = 1,   // One or two stop bits
    parameter uart_rx_pkg::rx_parity_t PARITY    = uart_rx_pkg::PARITY_NONE
) (
    input  logic                   Clk,
    input  logic                   Rst,
    input  logic                   rx_sync,
    input  logic                   tick,
    input  logic                   full,
    output logic                   restart,
    output uart_rx_pkg::rx_frame_t frame,
    output logic                   frame_valid,
    output logic                   rts
);

    localparam int TICK_W = $clog2(uart_rx_pkg::OVERSAMPLE);
    localparam int BIT_W  = $clog2(uart_rx_pkg::DATA_BITS);
    localparam logic [TICK_W-1:0] MID_TICK  = TICK_W'(uart_rx_pkg::OVERSAMPLE / 2 - 1);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(uart_rx_pkg::OVERSAMPLE - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(uart_rx_pkg::DATA_BITS - 1);
    localparam logic              LAST_STOP = 1'(STOP_BITS - 1);

    uart_rx_pkg::rx_state_t state;
    uart_rx_pkg::rx_state_t state_nxt;

    logic [TICK_W-1:0]                 tick_cnt;    // Ticks into the current bit
    logic [BIT_W-1:0]                  bit_cnt;     // Data bits already taken
    logic                              stop_cnt;    // Stop bits already taken
    logic [uart_rx_pkg::DATA_BITS-1:0] shift_reg;
    logic                              parity_bit;
    logic                              framing;
    logic                              start_mid;   // Tick at the middle of the start bit
    logic                              bit_end;     // Tick at the middle of a later bit

    assign start_mid = tick && (tick_cnt == MID_TICK);
    assign bit_end   = tick && (tick_cnt == LAST_TICK);

    // A low line seen while idle starts a frame and realigns the tick divider
    assign restart = (state == uart_rx_pkg::RX_IDLE) && !rx_sync;

    assign frame_valid      = (state == uart_rx_pkg::RX_DONE);   // RX_DONE lasts one cycle
    assign frame.data       = shift_reg;
    assign frame.parity_bit = parity_bit;
    assign frame.framing    = framing;

    always_comb begin
        state_nxt = state;
        case (state)
            uart_rx_pkg::RX_IDLE: begin
                if (!rx_sync) begin
                    state_nxt = uart_rx_pkg::RX_START;
                end
            end
            uart_rx_pkg::RX_START: begin
                // A line that is high again at mid-bit was only a glitch
                if (start_mid) begin
                    state_nxt = rx_sync ? uart_rx_pkg::RX_IDLE : uart_rx_pkg::RX_DATA;
                end
            end
            uart_rx_pkg::RX_DATA: begin
                if (bit_end && (bit_cnt == LAST_BIT)) begin
                    state_nxt = (PARITY == uart_rx_pkg::PARITY_NONE) ?
                                uart_rx_pkg::RX_STOP : uart_rx_pkg::RX_PARITY;
                end
            end
            uart_rx_pkg::RX_PARITY: begin
                if (bit_end) begin
                    state_nxt = uart_rx_pkg::RX_STOP;
                end
            end
            uart_rx_pkg::RX_STOP: begin
                if (bit_end && (stop_cnt == LAST_STOP)) begin
                    state_nxt = uart_rx_pkg::RX_DONE;
                end
            end
            default: state_nxt = uart_rx_pkg::RX_IDLE;   // RX_DONE and illegal codes
        endcase
    end

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            state    <= uart_rx_pkg::RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
            framing  <= 1'b0;
            rts      <= 1'b1;   // Idle with an empty FIFO
        end else begin
            state <= state_nxt;
            // Built from the next state so rts drops in the same cycle the FSM leaves idle
            rts   <= (state_nxt == uart_rx_pkg::RX_IDLE) && !full;
            case (state)
                uart_rx_pkg::RX_IDLE: begin
                    tick_cnt <= '0;
                    bit_cnt  <= '0;
                    stop_cnt <= 1'b0;
                    framing  <= 1'b0;
                end
                uart_rx_pkg::RX_START: begin
                    if (tick) begin
                        tick_cnt <= start_mid ? '0 : tick_cnt + 1'b1;   // Zero at mid start bit
                    end
                end
                default: begin
                    if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;   // Wraps every OVERSAMPLE ticks
                    end
                    if (bit_end && (state == uart_rx_pkg::RX_DATA)) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                    if (bit_end && (state == uart_rx_pkg::RX_STOP)) begin
                        stop_cnt <= stop_cnt + 1'b1;
                        framing  <= framing | !rx_sync;   // Any low stop bit is a framing error
                    end
                end
            endcase
        end
    end

    // Character and parity bit are payload and only meaningful with frame_valid
    always_ff @(posedge Clk) begin
        if ((state == uart_rx_pkg::RX_DATA) && bit_end) begin
            shift_reg <= {rx_sync, shift_reg[uart_rx_pkg::DATA_BITS-1:1]};   // LSB arrives first
        end
        if (state == uart_rx_pkg::RX_IDLE) begin
            parity_bit <= 1'b0;   // Stays zero when there is no parity bit
        end else if ((state == uart_rx_pkg::RX_PARITY) && bit_end) begin
            parity_bit <= rx_sync;
        end
    end

endmodule

//--- hw/uart_rx_frame_check.sv
module uart_rx_frame_check #(
    parameter uart_rx_pkg::rx_parity_t PARITY = uart_rx_pkg::PARITY_NONE
) (
    input  logic                   Clk,
    input  logic                   Rst,
    input  uart_rx_pkg::rx_frame_t frame,
    input  logic                   frame_valid,
    output uart_rx_pkg::rx_word_t  word,
    output logic                   word_valid
);

    logic parity_sum;   // XOR over the data bits and the received parity bit
    logic parity_err;

    assign parity_sum = ^{frame.data, frame.parity_bit};

    // Even parity wants the total count of ones even and odd parity wants it odd
    always_comb begin
        case (PARITY)
            uart_rx_pkg::PARITY_EVEN: begin
                parity_err = parity_sum;
            end
            uart_rx_pkg::PARITY_ODD: begin
                parity_err = !parity_sum;
            end
            default: begin
                parity_err = 1'b0;   // No parity bit so nothing to check
            end
        endcase
    end

    // The strobe is delayed by exactly one cycle to line up with the registered word
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= frame_valid;
        end
    end

    // Character and flags are captured together so the FIFO stores one coherent entry
    always_ff @(posedge Clk) begin
        if (frame_valid) begin
            word.data        <= frame.data;
            word.err.parity  <= parity_err;
            word.err.framing <= frame.framing;   // Passed through from the sampler
        end
    end

endmodule

//--- hw/uart_rx_fifo.sv
module uart_rx_fifo #(
    parameter int FIFO_DEPTH = 4   // Must be a power of two
) (
    input  logic                  Clk,
    input  logic                  Rst,
    input  uart_rx_pkg::rx_word_t word,
    input  logic                  word_valid,
    input  logic                  pop,
    output uart_rx_pkg::rx_word_t rx_word,
    output logic                  data_rdy,
    output logic                  full,
    output logic                  overrun
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    uart_rx_pkg::rx_word_t mem [FIFO_DEPTH];

    // One extra bit on each pointer tells a full buffer from an empty one
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic           empty;
    logic           do_push;
    logic           do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign do_pop = pop && !empty;   // Popping an empty FIFO does nothing

    // A pop in the same cycle frees the slot the push needs
    assign do_push = word_valid && (!full || do_pop);

    // First word fall through so the head entry is always on the output
    assign rx_word  = mem[rd_ptr[PTR_W-1:0]];
    assign data_rdy = !empty;

    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage array carries data only
    always_ff @(posedge Clk) begin
        if (do_push) begin
            mem[wr_ptr[PTR_W-1:0]] <= word;
        end
    end

    // Sticky overrun raised when a word is dropped and held until the next pop
    always_ff @(posedge Clk or posedge Rst) begin
        if (Rst) begin
            overrun <= 1'b0;
        end else if (word_valid && full && !pop) begin
            overrun <= 1'b1;   // That word is lost
        end else if (pop) begin
            overrun <= 1'b0;
        end
    end

endmodule

//--- hw/uart_rx_top.sv
module uart_rx_top #(
    parameter int                      CLK_FREQ   = 50_000_000,
    parameter int                      BAUD_RATE  = 115_200,
    parameter int                      STOP_BITS  = 1,
    parameter uart_rx_pkg::rx_parity_t PARITY     = uart_rx_pkg::PARITY_NONE,
    parameter int                      FIFO_DEPTH = 4
) (
    input  logic                  Clk,
    input  logic                  Rst,
    input  logic                  rx,
    input  logic                  pop,
    output logic                  rts,
    output logic                  data_rdy,
    output logic                  overrun,
    output uart_rx_pkg::rx_word_t rx_word
);

    logic                   rx_sync;
    logic                   tick;
    logic                   restart;      // From the FSM back to the baud divider
    logic                   full;         // From the FIFO back to the FSM for rts
    uart_rx_pkg::rx_frame_t frame;
    logic                   frame_valid;
    uart_rx_pkg::rx_word_t  word;
    logic                   word_valid;

    // Synchronizer and baud tick
    uart_rx_oversample #(
        .CLK_FREQ (CLK_FREQ),
        .BAUD_RATE(BAUD_RATE)
    ) u_oversample (
        .Clk    (Clk),
        .Rst    (Rst),
        .rx     (rx),
        .restart(restart),
        .rx_sync(rx_sync),
        .tick   (tick)
    );

    uart_rx_sampler #(
        .STOP_BITS(STOP_BITS),
        .PARITY   (PARITY)
    ) u_sampler (
        .Clk        (Clk),
        .Rst        (Rst),
        .rx_sync    (rx_sync),
        .tick       (tick),
        .full       (full),
        .restart    (restart),
        .frame      (frame),
        .frame_valid(frame_valid),
        .rts        (rts)
    );

    uart_rx_frame_check #(
        .PARITY(PARITY)
    ) u_frame_check (
        .Clk        (Clk),
        .Rst        (Rst),
        .frame      (frame),
        .frame_valid(frame_valid),
        .word       (word),
        .word_valid (word_valid)
    );

    // Receive buffer facing the host
    uart_rx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .Clk       (Clk),
        .Rst       (Rst),
        .word      (word),
        .word_valid(word_valid),
        .pop       (pop),
        .rx_word   (rx_word),
        .data_rdy  (data_rdy),
        .full      (full),
        .overrun   (overrun)
    );

endmodule

//--- dv/uart_rx_assert.sv
module uart_rx_assert (
    input logic                   Clk,
    input logic                   Rst,
    input logic                   frame_valid,
    input logic                   word_valid,
    input logic                   rts,
    input logic                   data_rdy,
    input logic                   overrun,
    input uart_rx_pkg::rx_state_t sampler_state   // FSM state taken from the sampler
);
    timeunit 1ns;
    timeprecision 1ps;

    // The stage strobes never last longer than one cycle
    frame_valid_pulse: assert property (@(posedge Clk) disable iff (Rst)
        frame_valid |=> !frame_valid)
        else $error("frame_valid stayed high for more than one cycle");
    word_valid_pulse: assert property (@(posedge Clk) disable iff (Rst) word_valid |=> !word_valid)
        else $error("word_valid stayed high for more than one cycle");

    // The checker adds exactly one register stage
    word_follows_frame: assert property (@(posedge Clk) disable iff (Rst)
        frame_valid |=> word_valid)
        else $error("word_valid did not follow frame_valid");
    word_needs_frame: assert property (@(posedge Clk) disable iff (Rst)
        word_valid |-> $past(frame_valid))
        else $error("word_valid without frame_valid one cycle before");

    // Flow control is only granted while the FSM waits for a start edge
    rts_only_idle: assert property (@(posedge Clk) disable iff (Rst)
        (sampler_state != uart_rx_pkg::RX_IDLE) |-> !rts)
        else $error("rts high while the sampler is busy");

    // Output side comes out of reset empty and without errors
    clean_after_reset: assert property (@(posedge Clk) $fell(Rst) |-> (!data_rdy && !overrun))
        else $error("data_rdy or overrun high right after reset");

endmodule

bind uart_rx_top uart_rx_assert u_assert (
    .Clk          (Clk),
    .Rst          (Rst),
    .frame_valid  (frame_valid),
    .word_valid   (word_valid),
    .rts          (rts),
    .data_rdy     (data_rdy),
    .overrun      (overrun),
    .sampler_state(u_sampler.state)
);

//--- dv/uart_rx_tb.sv
module uart_rx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 100;
    localparam int BIT_CYCLES    = 64;   // 4 cycles per tick and 16 ticks per bit
    localparam int FRAME_BITS    = 12;   // Start, 8 data, parity and 2 stop bits
    localparam int TABLE_LEN     = 10;
    localparam int OVR_FRAMES    = 5;    // One more than the FIFO holds
    localparam int GLITCH_CYCLES = 16;   // About 4 ticks of low line
    localparam int RDY_TIMEOUT   = 4 * BIT_CYCLES;
    // Every frame gets 14 bit times and the glitch test 16 more, plus a margin
    localparam int WATCHDOG_NS   =
        (TABLE_LEN * 14 + OVR_FRAMES * 14 + 16 + 20) * BIT_CYCLES * CLK_PERIOD;

    logic                  Clk;
    logic                  Rst;
    logic                  rx;
    logic                  pop;
    logic                  rts;
    logic                  data_rdy;
    logic                  overrun;
    uart_rx_pkg::rx_word_t rx_word;

    int          seed;
    logic [31:0] rnd_word;

    // Stimulus table and the word each entry should produce
    logic [7:0]            tbl_data     [TABLE_LEN];
    logic                  tbl_bad_par  [TABLE_LEN];
    logic                  tbl_bad_stop [TABLE_LEN];
    uart_rx_pkg::rx_word_t tbl_exp      [TABLE_LEN];
    logic [7:0]            ovr_data     [OVR_FRAMES];

    uart_rx_top #(
        .CLK_FREQ  (10_000_000),
        .BAUD_RATE (156_250),
        .STOP_BITS (2),
        .PARITY    (uart_rx_pkg::PARITY_EVEN),
        .FIFO_DEPTH(4)
    ) dut (
        .Clk     (Clk),
        .Rst     (Rst),
        .rx      (rx),
        .pop     (pop),
        .rts     (rts),
        .data_rdy(data_rdy),
        .overrun (overrun),
        .rx_word (rx_word)
    );

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    task automatic set_entry(input int idx, input logic [7:0] data, input logic bad_par,
                             input logic bad_stop, input logic [9:0] exp_word);
        tbl_data[idx]     = data;
        tbl_bad_par[idx]  = bad_par;
        tbl_bad_stop[idx] = bad_stop;
        tbl_exp[idx]      = exp_word;   // Data on top, then parity and framing flags
    endtask

    task automatic fill_table();
        seed = 32'hb729_c139;
        set_entry(0, 8'h55, 1'b0, 1'b0, {8'h55, 2'b00});
        set_entry(1, 8'ha3, 1'b0, 1'b0, {8'ha3, 2'b00});
        set_entry(2, 8'h00, 1'b0, 1'b0, {8'h00, 2'b00});
        set_entry(3, 8'hff, 1'b0, 1'b0, {8'hff, 2'b00});
        rnd_word = $random(seed);
        set_entry(4, rnd_word[7:0], 1'b0, 1'b0, {rnd_word[7:0], 2'b00});
        set_entry(5, 8'h3c, 1'b1, 1'b0, {8'h3c, 2'b10});   // Flipped parity bit
        set_entry(6, 8'h81, 1'b0, 1'b1, {8'h81, 2'b01});   // First stop bit low
        rnd_word = $random(seed);
        set_entry(7, rnd_word[7:0], 1'b0, 1'b0, {rnd_word[7:0], 2'b00});
        set_entry(8, 8'h7e, 1'b1, 1'b1, {8'h7e, 2'b11});   // Both errors at once
        set_entry(9, 8'h01, 1'b0, 1'b0, {8'h01, 2'b00});
        ovr_data[0] = 8'h11;
        ovr_data[1] = 8'h22;
        ovr_data[2] = 8'h33;
        ovr_data[3] = 8'h44;
        ovr_data[4] = 8'h55;   // This one finds the FIFO full
    endtask

    // Sends one frame LSB first with even parity, starting on a falling edge
    task automatic send_frame(input logic [7:0] data, input logic flip_parity,
                              input logic low_stop);
        logic [FRAME_BITS-1:0] bits;
        bits = {1'b1, !low_stop, (^data) ^ flip_parity, data, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            rx = bits[i];
            repeat (BIT_CYCLES) @(negedge Clk);
        end
        rx = 1'b1;   // Line back to idle
    endtask

    task automatic wait_data_rdy();
        int cycles;
        cycles = 0;
        while (!data_rdy) begin
            if (cycles == RDY_TIMEOUT) begin
                abort_run("No received word showed up within four bit times");
            end
            @(negedge Clk);
            cycles++;
        end
    endtask

    task automatic pop_word();
        pop = 1'b1;
        @(negedge Clk);
        pop = 1'b0;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("The run took longer than all the frames should need and was stopped");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        Rst = 1'b1;
        rx  = 1'b1;
        pop = 1'b0;
        fill_table();
        repeat (2) @(negedge Clk);
        Rst = 1'b0;
        @(negedge Clk);
        check_value("rts", 32'(rts), 32'd1);   // Idle with an empty FIFO
        check_value("data_rdy", 32'(data_rdy), 32'd0);
        check_value("overrun", 32'(overrun), 32'd0);

        // One frame at a time, popped before the next one
        for (int i = 0; i < TABLE_LEN; i++) begin
            check_value("rts", 32'(rts), 32'd1);
            send_frame(tbl_data[i], tbl_bad_par[i], tbl_bad_stop[i]);
            wait_data_rdy();
            check_value("rx_word", 32'(rx_word), 32'(tbl_exp[i]));
            pop_word();
            check_value("data_rdy", 32'(data_rdy), 32'd0);   // That pop emptied the FIFO
        end

        // A short low pulse is rejected at mid start bit
        rx = 1'b0;
        repeat (GLITCH_CYCLES) @(negedge Clk);
        rx = 1'b1;
        repeat (2 * BIT_CYCLES) @(negedge Clk);
        check_value("data_rdy", 32'(data_rdy), 32'd0);
        check_value("rts", 32'(rts), 32'd1);
        send_frame(8'hc5, 1'b0, 1'b0);
        wait_data_rdy();
        check_value("rx_word", 32'(rx_word), 32'({8'hc5, 2'b00}));
        pop_word();

        // Fill the FIFO and push one word past it
        for (int i = 0; i < OVR_FRAMES; i++) begin
            send_frame(ovr_data[i], 1'b0, 1'b0);
            if (i == OVR_FRAMES - 2) begin
                check_value("rts", 32'(rts), 32'd0);   // FIFO full holds the sender off
                check_value("overrun", 32'(overrun), 32'd0);
            end
        end
        check_value("overrun", 32'(overrun), 32'd1);
        for (int i = 0; i < OVR_FRAMES - 1; i++) begin
            check_value("data_rdy", 32'(data_rdy), 32'd1);
            check_value("rx_word", 32'(rx_word), 32'({ovr_data[i], 2'b00}));
            pop_word();
            check_value("overrun", 32'(overrun), 32'd0);
        end
        check_value("data_rdy", 32'(data_rdy), 32'd0);   // Fifth word was dropped

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- files.f
hw/uart_rx_pkg.sv
hw/uart_rx_oversample.sv
hw/uart_rx_sampler.sv
hw/uart_rx_frame_check.sv
hw/uart_rx_fifo.sv
hw/uart_rx_top.sv
dv/uart_rx_assert.sv
dv/uart_rx_tb.sv

//--- run.sh
#!/bin/sh
# Build the simulation with Verilator and run it; a nonzero exit means failure
verilator --binary --timing --assert --top-module uart_rx_tb -f files.f -o uart_rx_sim \
    && ./obj_dir/uart_rx_sim \
    || { echo "Build or run of the UART receiver testbench returned an error"; exit 1; }
exit 0
